/* src/sc_pkg.sv */
// Shared definitions for the step-and-compare checker
// Word and index widths, CSR address map and scheduler states
package sc_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int CSR_ADDR_W = 12;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  // Machine mode CSRs
  localparam csr_addr_t CSR_MSTATUS       = 12'h300;
  localparam csr_addr_t CSR_MISA          = 12'h301;
  localparam csr_addr_t CSR_MIE           = 12'h304;
  localparam csr_addr_t CSR_MTVEC         = 12'h305;
  localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
  localparam csr_addr_t CSR_MSCRATCH      = 12'h340;
  localparam csr_addr_t CSR_MEPC          = 12'h341;
  localparam csr_addr_t CSR_MCAUSE        = 12'h342;
  localparam csr_addr_t CSR_MIP           = 12'h344;
  localparam csr_addr_t CSR_PMPCFG0       = 12'h3A0;
  localparam csr_addr_t CSR_PMPCFG1       = 12'h3A1;
  localparam csr_addr_t CSR_PMPCFG2       = 12'h3A2;
  localparam csr_addr_t CSR_PMPCFG3       = 12'h3A3;

  // Trigger and debug CSRs
  localparam csr_addr_t CSR_TSELECT       = 12'h7A0;
  localparam csr_addr_t CSR_TDATA1        = 12'h7A1;
  localparam csr_addr_t CSR_TDATA2        = 12'h7A2;
  localparam csr_addr_t CSR_TDATA3        = 12'h7A3;
  localparam csr_addr_t CSR_TINFO         = 12'h7A4;
  localparam csr_addr_t CSR_MCONTEXT      = 12'h7A8;
  localparam csr_addr_t CSR_SCONTEXT      = 12'h7AA;
  localparam csr_addr_t CSR_DCSR          = 12'h7B0;
  localparam csr_addr_t CSR_DPC           = 12'h7B1;
  localparam csr_addr_t CSR_DSCRATCH0     = 12'h7B2;
  localparam csr_addr_t CSR_DSCRATCH1     = 12'h7B3;

  // Counters and ID registers
  localparam csr_addr_t CSR_MINSTRET      = 12'hB02;
  localparam csr_addr_t CSR_MINSTRETH     = 12'hB82;
  localparam csr_addr_t CSR_CYCLE         = 12'hC00;
  localparam csr_addr_t CSR_TIME          = 12'hC01;
  localparam csr_addr_t CSR_INSTRET       = 12'hC02;
  localparam csr_addr_t CSR_CYCLEH        = 12'hC80;
  localparam csr_addr_t CSR_INSTRETH      = 12'hC82;
  localparam csr_addr_t CSR_MVENDORID     = 12'hF11;
  localparam csr_addr_t CSR_MARCHID       = 12'hF12;
  localparam csr_addr_t CSR_MIMPID        = 12'hF13;
  localparam csr_addr_t CSR_MHARTID       = 12'hF14;

  // First address of each hpm counter block, counters 3 to 31
  localparam csr_addr_t CSR_MHPMCOUNTER3  = 12'hB03;
  localparam csr_addr_t CSR_MHPMCOUNTERH3 = 12'hB83;
  localparam csr_addr_t CSR_HPMCOUNTER3   = 12'hC03;
  localparam csr_addr_t CSR_HPMCOUNTERH3  = 12'hC83;
  localparam int        HPM_SPAN          = 29;

  typedef enum logic [2:0] {
    SC_IDLE,
    SC_RTL_WAIT,
    SC_RM_STEP,
    SC_RM_WAIT,
    SC_CMP
  } sched_state_e;

endpackage

/* src/sc_retire_capture.sv */
// Retirement record register
// Loads one retirement on capture_i, used once for the core and once for the model
`timescale 1ns/1ps

module sc_retire_capture import sc_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      capture_i,
  input  xlen_t     pc_i,
  input  logic      gpr_we_i,
  input  reg_addr_t gpr_addr_i,
  input  xlen_t     gpr_data_i,
  input  logic      csr_we_i,
  input  csr_addr_t csr_addr_i,
  input  xlen_t     csr_data_i,
  output xlen_t     pc_o,
  output logic      gpr_we_o,
  output reg_addr_t gpr_addr_o,
  output xlen_t     gpr_data_o,
  output logic      csr_we_o,
  output csr_addr_t csr_addr_o,
  output xlen_t     csr_data_o
);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_o       <= '0;
      gpr_we_o   <= 1'b0;
      gpr_addr_o <= '0;
      gpr_data_o <= '0;
      csr_we_o   <= 1'b0;
      csr_addr_o <= '0;
      csr_data_o <= '0;
    end else if (capture_i) begin
      pc_o       <= pc_i;
      gpr_we_o   <= gpr_we_i;
      gpr_addr_o <= gpr_addr_i;
      gpr_data_o <= gpr_data_i;
      csr_we_o   <= csr_we_i;
      csr_addr_o <= csr_addr_i;
      csr_data_o <= csr_data_i;
    end
  end

endmodule

/* src/sc_step_sched.sv */
// Step scheduler
// Waits for one core retirement, holds the core, steps the reference model
// once and then triggers the compare of both records
`timescale 1ns/1ps

module sc_step_sched import sc_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic rtl_retire_i,
  input  logic rm_valid_i,
  output logic rtl_capture_o,
  output logic rm_capture_o,
  output logic rm_step_o,
  output logic cmp_o,
  output logic rtl_hold_o
);

  sched_state_e state_q;
  sched_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      SC_IDLE:     state_d = SC_RTL_WAIT;
      SC_RTL_WAIT: if (rtl_retire_i) state_d = SC_RM_STEP;
      SC_RM_STEP:  state_d = SC_RM_WAIT;
      SC_RM_WAIT:  if (rm_valid_i) state_d = SC_CMP;
      SC_CMP:      state_d = SC_RTL_WAIT;
      default:     state_d = SC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= SC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Records are taken only in their own wait state
  assign rtl_capture_o = (state_q == SC_RTL_WAIT) && rtl_retire_i;
  assign rm_capture_o  = (state_q == SC_RM_WAIT) && rm_valid_i;

  assign rm_step_o = (state_q == SC_RM_STEP);
  assign cmp_o     = (state_q == SC_CMP);

  // Core stays frozen from the model request until the compare is done
  assign rtl_hold_o = (state_q == SC_RM_STEP) || (state_q == SC_RM_WAIT) ||
                      (state_q == SC_CMP);

  // Core must honour the hold level
  a_no_retire_in_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
    rtl_hold_o |-> !rtl_retire_i
  );

  // Model answers only to an outstanding step
  a_rm_valid_in_wait: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (state_q != SC_RM_WAIT) |-> !rm_valid_i
  );

  a_rm_step_pulse: assert property (
    @(posedge clk_i) disable iff (reset_i)
    rm_step_o |=> !rm_step_o
  );

endmodule

/* src/sc_csr_filter.sv */
// CSR ignore policy
// Decodes the reported CSR address, flags known registers and decides
// whether the write is compared under the current mode levels
`timescale 1ns/1ps

module sc_csr_filter import sc_pkg::*; (
  input  csr_addr_t csr_addr_i,
  input  logic      stall_sim_i,
  input  logic      deferint_i,
  input  logic      debug_mode_i,
  input  logic      ignore_dpc_i,
  output logic      check_o,
  output logic      known_o
);

  logic named;
  logic ignore;
  logic hpm_hit;

  function automatic logic in_hpm_block(csr_addr_t addr, csr_addr_t base);
    return (addr >= base) && (addr < base + csr_addr_t'(HPM_SPAN));
  endfunction

  assign hpm_hit = in_hpm_block(csr_addr_i, CSR_MHPMCOUNTER3)  ||
                   in_hpm_block(csr_addr_i, CSR_MHPMCOUNTERH3) ||
                   in_hpm_block(csr_addr_i, CSR_HPMCOUNTER3)   ||
                   in_hpm_block(csr_addr_i, CSR_HPMCOUNTERH3);

  always_comb begin
    named  = 1'b1;
    ignore = 1'b0;
    case (csr_addr_i)
      // Trap state only lines up when interrupts are deferred
      CSR_MSTATUS, CSR_MEPC, CSR_MCAUSE: ignore = !deferint_i;
      CSR_DCSR: ignore = !debug_mode_i;
      CSR_DPC:  ignore = !debug_mode_i || ignore_dpc_i;
      // Timing dependent or implementation specific values
      CSR_MIP, CSR_TIME, CSR_CYCLE, CSR_CYCLEH, CSR_INSTRET, CSR_INSTRETH,
      CSR_MCONTEXT, CSR_SCONTEXT, CSR_MIMPID: ignore = 1'b1;
      CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MHARTID,
      CSR_DSCRATCH0, CSR_DSCRATCH1,
      CSR_PMPCFG0, CSR_PMPCFG1, CSR_PMPCFG2, CSR_PMPCFG3,
      CSR_TSELECT, CSR_TDATA1, CSR_TDATA2, CSR_TDATA3, CSR_TINFO,
      CSR_MARCHID, CSR_MVENDORID, CSR_MCOUNTINHIBIT,
      CSR_MINSTRET, CSR_MINSTRETH: ignore = 1'b0;
      default: named = 1'b0;
    endcase
  end

  assign known_o = named || hpm_hit;

  // hpm blocks are never compared, so only named registers can be checked
  assign check_o = named && !ignore && !stall_sim_i;

endmodule

/* src/sc_compare.sv */
// Record comparator
// Compares the captured core and model retirements on cmp_i and registers
// the PC, GPR and CSR mismatch flags one cycle later
`timescale 1ns/1ps

module sc_compare import sc_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      cmp_i,
  input  xlen_t     rtl_pc_i,
  input  logic      rtl_gpr_we_i,
  input  reg_addr_t rtl_gpr_addr_i,
  input  xlen_t     rtl_gpr_data_i,
  input  logic      rtl_csr_we_i,
  input  csr_addr_t rtl_csr_addr_i,
  input  xlen_t     rtl_csr_data_i,
  input  xlen_t     rm_pc_i,
  input  logic      rm_gpr_we_i,
  input  reg_addr_t rm_gpr_addr_i,
  input  xlen_t     rm_gpr_data_i,
  input  logic      rm_csr_we_i,
  input  csr_addr_t rm_csr_addr_i,
  input  xlen_t     rm_csr_data_i,
  input  logic      stall_sim_i,
  input  logic      deferint_i,
  input  logic      debug_mode_i,
  input  logic      ignore_dpc_i,
  output logic      compare_done_o,
  output logic      pc_mismatch_o,
  output logic      gpr_mismatch_o,
  output logic      csr_mismatch_o,
  output logic      unknown_csr_o,
  output logic      gpr_checked_o,
  output logic      csr_checked_o
);

  logic csr_check;
  logic csr_known;
  logic rtl_gpr_wr;
  logic rm_gpr_wr;

  sc_csr_filter csr_filter_i (
    .csr_addr_i   (rm_csr_addr_i),
    .stall_sim_i  (stall_sim_i),
    .deferint_i   (deferint_i),
    .debug_mode_i (debug_mode_i),
    .ignore_dpc_i (ignore_dpc_i),
    .check_o      (csr_check),
    .known_o      (csr_known)
  );

  // Writes to x0 do not count as writebacks
  assign rtl_gpr_wr = rtl_gpr_we_i && (rtl_gpr_addr_i != '0);
  assign rm_gpr_wr  = rm_gpr_we_i && (rm_gpr_addr_i != '0);

  // Check qualifiers, valid while cmp_i is high and counted on that edge
  assign gpr_checked_o = rtl_gpr_wr || rm_gpr_wr;
  assign csr_checked_o = rm_csr_we_i && csr_check;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      compare_done_o <= 1'b0;
      pc_mismatch_o  <= 1'b0;
      gpr_mismatch_o <= 1'b0;
      csr_mismatch_o <= 1'b0;
      unknown_csr_o  <= 1'b0;
    end else begin
      compare_done_o <= cmp_i;
      if (cmp_i) begin
        pc_mismatch_o  <= (rtl_pc_i != rm_pc_i);
        gpr_mismatch_o <= gpr_checked_o &&
                          ((rtl_gpr_wr != rm_gpr_wr) ||
                           (rtl_gpr_addr_i != rm_gpr_addr_i) ||
                           (rtl_gpr_data_i != rm_gpr_data_i));
        csr_mismatch_o <= csr_checked_o &&
                          (!rtl_csr_we_i ||
                           (rtl_csr_addr_i != rm_csr_addr_i) ||
                           (rtl_csr_data_i != rm_csr_data_i));
        unknown_csr_o  <= rm_csr_we_i && !csr_known;
      end
    end
  end

  a_done_pulse: assert property (
    @(posedge clk_i) disable iff (reset_i)
    compare_done_o |=> !compare_done_o
  );

endmodule

/* src/sc_check_counters.sv */
// Check counters
// Counts compares and the GPR and CSR checks that applied, and raises a
// sticky flag once the instruction count reaches the limit
`timescale 1ns/1ps

module sc_check_counters #(
  parameter int          CNT_W     = 32,
  parameter int unsigned MAX_INSNS = 10_000_000
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             compare_done_i,
  input  logic             gpr_checked_i,
  input  logic             csr_checked_i,
  output logic [CNT_W-1:0] num_pc_checks_o,
  output logic [CNT_W-1:0] num_gpr_checks_o,
  output logic [CNT_W-1:0] num_csr_checks_o,
  output logic [CNT_W-1:0] insn_count_o,
  output logic             limit_o
);

  localparam logic [CNT_W-1:0] LIMIT = CNT_W'(MAX_INSNS);

  logic [CNT_W-1:0] insn_next;

  assign insn_next = insn_count_o + CNT_W'(compare_done_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      num_pc_checks_o  <= '0;
      num_gpr_checks_o <= '0;
      num_csr_checks_o <= '0;
      insn_count_o     <= '0;
      limit_o          <= 1'b0;
    end else begin
      insn_count_o <= insn_next;
      if (compare_done_i) begin
        num_pc_checks_o <= num_pc_checks_o + 1'b1;
        if (gpr_checked_i) num_gpr_checks_o <= num_gpr_checks_o + 1'b1;
        if (csr_checked_i) num_csr_checks_o <= num_csr_checks_o + 1'b1;
      end
      if (insn_next >= LIMIT) limit_o <= 1'b1;
    end
  end

  // GPR and CSR counts never pass the compare count, so this covers all four
  a_no_wrap: assert property (
    @(posedge clk_i) disable iff (reset_i)
    compare_done_i |-> !(&num_pc_checks_o) && !(&insn_count_o)
  );

endmodule

/* src/sc_top.sv */
// Step-and-compare checker top level
// Sequences one core retirement against one reference model step,
// compares the two records and keeps the check counters
`timescale 1ns/1ps

module sc_top import sc_pkg::*; #(
  parameter int          CNT_W     = 32,
  parameter int unsigned MAX_INSNS = 10_000_000
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             rtl_retire_i,
  input  xlen_t            rtl_pc_i,
  input  logic             rtl_gpr_we_i,
  input  reg_addr_t        rtl_gpr_addr_i,
  input  xlen_t            rtl_gpr_data_i,
  input  logic             rtl_csr_we_i,
  input  csr_addr_t        rtl_csr_addr_i,
  input  xlen_t            rtl_csr_data_i,
  output logic             rtl_hold_o,
  output logic             rm_step_o,
  input  logic             rm_valid_i,
  input  xlen_t            rm_pc_i,
  input  logic             rm_gpr_we_i,
  input  reg_addr_t        rm_gpr_addr_i,
  input  xlen_t            rm_gpr_data_i,
  input  logic             rm_csr_we_i,
  input  csr_addr_t        rm_csr_addr_i,
  input  xlen_t            rm_csr_data_i,
  input  logic             stall_sim_i,
  input  logic             deferint_i,
  input  logic             debug_mode_i,
  input  logic             ignore_dpc_i,
  output logic             compare_done_o,
  output logic             pc_mismatch_o,
  output logic             gpr_mismatch_o,
  output logic             csr_mismatch_o,
  output logic             unknown_csr_o,
  output logic [CNT_W-1:0] num_pc_checks_o,
  output logic [CNT_W-1:0] num_gpr_checks_o,
  output logic [CNT_W-1:0] num_csr_checks_o,
  output logic [CNT_W-1:0] insn_count_o,
  output logic             limit_o
);

  logic      rtl_capture;
  logic      rm_capture;
  logic      cmp;
  logic      gpr_checked;
  logic      csr_checked;
  xlen_t     rtl_pc_q, rm_pc_q;
  logic      rtl_gpr_we_q, rm_gpr_we_q;
  reg_addr_t rtl_gpr_addr_q, rm_gpr_addr_q;
  xlen_t     rtl_gpr_data_q, rm_gpr_data_q;
  logic      rtl_csr_we_q, rm_csr_we_q;
  csr_addr_t rtl_csr_addr_q, rm_csr_addr_q;
  xlen_t     rtl_csr_data_q, rm_csr_data_q;

  sc_step_sched sched_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .rtl_retire_i  (rtl_retire_i),
    .rm_valid_i    (rm_valid_i),
    .rtl_capture_o (rtl_capture),
    .rm_capture_o  (rm_capture),
    .rm_step_o     (rm_step_o),
    .cmp_o         (cmp),
    .rtl_hold_o    (rtl_hold_o)
  );

  sc_retire_capture rtl_capture_i (
    .clk_i (clk_i), .reset_i (reset_i), .capture_i (rtl_capture),
    .pc_i       (rtl_pc_i),       .pc_o       (rtl_pc_q),
    .gpr_we_i   (rtl_gpr_we_i),   .gpr_we_o   (rtl_gpr_we_q),
    .gpr_addr_i (rtl_gpr_addr_i), .gpr_addr_o (rtl_gpr_addr_q),
    .gpr_data_i (rtl_gpr_data_i), .gpr_data_o (rtl_gpr_data_q),
    .csr_we_i   (rtl_csr_we_i),   .csr_we_o   (rtl_csr_we_q),
    .csr_addr_i (rtl_csr_addr_i), .csr_addr_o (rtl_csr_addr_q),
    .csr_data_i (rtl_csr_data_i), .csr_data_o (rtl_csr_data_q)
  );

  sc_retire_capture rm_capture_i (
    .clk_i (clk_i), .reset_i (reset_i), .capture_i (rm_capture),
    .pc_i       (rm_pc_i),       .pc_o       (rm_pc_q),
    .gpr_we_i   (rm_gpr_we_i),   .gpr_we_o   (rm_gpr_we_q),
    .gpr_addr_i (rm_gpr_addr_i), .gpr_addr_o (rm_gpr_addr_q),
    .gpr_data_i (rm_gpr_data_i), .gpr_data_o (rm_gpr_data_q),
    .csr_we_i   (rm_csr_we_i),   .csr_we_o   (rm_csr_we_q),
    .csr_addr_i (rm_csr_addr_i), .csr_addr_o (rm_csr_addr_q),
    .csr_data_i (rm_csr_data_i), .csr_data_o (rm_csr_data_q)
  );

  sc_compare compare_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .cmp_i          (cmp),
    .rtl_pc_i       (rtl_pc_q),
    .rtl_gpr_we_i   (rtl_gpr_we_q),
    .rtl_gpr_addr_i (rtl_gpr_addr_q),
    .rtl_gpr_data_i (rtl_gpr_data_q),
    .rtl_csr_we_i   (rtl_csr_we_q),
    .rtl_csr_addr_i (rtl_csr_addr_q),
    .rtl_csr_data_i (rtl_csr_data_q),
    .rm_pc_i        (rm_pc_q),
    .rm_gpr_we_i    (rm_gpr_we_q),
    .rm_gpr_addr_i  (rm_gpr_addr_q),
    .rm_gpr_data_i  (rm_gpr_data_q),
    .rm_csr_we_i    (rm_csr_we_q),
    .rm_csr_addr_i  (rm_csr_addr_q),
    .rm_csr_data_i  (rm_csr_data_q),
    .stall_sim_i    (stall_sim_i),
    .deferint_i     (deferint_i),
    .debug_mode_i   (debug_mode_i),
    .ignore_dpc_i   (ignore_dpc_i),
    .compare_done_o (compare_done_o),
    .pc_mismatch_o  (pc_mismatch_o),
    .gpr_mismatch_o (gpr_mismatch_o),
    .csr_mismatch_o (csr_mismatch_o),
    .unknown_csr_o  (unknown_csr_o),
    .gpr_checked_o  (gpr_checked),
    .csr_checked_o  (csr_checked)
  );

  // Counters take the compare strobe so they move with the registered flags
  sc_check_counters #(
    .CNT_W     (CNT_W),
    .MAX_INSNS (MAX_INSNS)
  ) counters_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .compare_done_i   (cmp),
    .gpr_checked_i    (gpr_checked),
    .csr_checked_i    (csr_checked),
    .num_pc_checks_o  (num_pc_checks_o),
    .num_gpr_checks_o (num_gpr_checks_o),
    .num_csr_checks_o (num_csr_checks_o),
    .insn_count_o     (insn_count_o),
    .limit_o          (limit_o)
  );

endmodule

/* tb/sc_tb_tasks.svh */
// Testbench tasks for the step-and-compare checker
// Result checks, core and model drivers, one full step and the directed tests
`ifndef SC_TB_TASKS_SVH
`define SC_TB_TASKS_SVH

task automatic check_flag(input string name, input logic exp, input logic act);
  num_checks++;
  if (act !== exp) begin
    num_errors++;
    $display("ERR %0t %s expected %0b actual %0b", $time, name, exp, act);
  end
endtask

task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                           input logic [CNT_W-1:0] act);
  num_checks++;
  if (act !== exp) begin
    num_errors++;
    $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
  end
endtask

task automatic start_test(input string name);
  test_num++;
  cur_test = name;
  err_mark = num_errors;
endtask

task automatic finish_test();
  if (num_errors == err_mark) begin
    $display("test %0d %s: ok", test_num, cur_test);
  end else begin
    tests_failed++;
    $display("test %0d %s: %0d errors", test_num, cur_test, num_errors - err_mark);
  end
endtask

// Synchronous reset, left in the cycle where the core may retire
task automatic apply_reset();
  reset_i = 1'b1;
  repeat (RESET_CYCLES) @(negedge clk_i);
  reset_i = 1'b0;
  @(negedge clk_i);
  exp_pc_cnt  = '0;
  exp_gpr_cnt = '0;
  exp_csr_cnt = '0;
  exp_insn    = '0;
endtask

// Same random record on both sides, tests then change single fields
task automatic make_record(input logic gpr_we, input reg_addr_t rd,
                           input logic csr_we, input csr_addr_t csr);
  c_pc  = $urandom & 32'hFFFF_FFFC;
  c_gwe = gpr_we;
  c_ga  = rd;
  c_gd  = $urandom;
  c_cwe = csr_we;
  c_ca  = csr;
  c_cd  = $urandom;
  m_pc  = c_pc;
  m_gwe = c_gwe;
  m_ga  = c_ga;
  m_gd  = c_gd;
  m_cwe = c_cwe;
  m_ca  = c_ca;
  m_cd  = c_cd;
endtask

task automatic drive_core();
  rtl_pc_i       = c_pc;
  rtl_gpr_we_i   = c_gwe;
  rtl_gpr_addr_i = c_ga;
  rtl_gpr_data_i = c_gd;
  rtl_csr_we_i   = c_cwe;
  rtl_csr_addr_i = c_ca;
  rtl_csr_data_i = c_cd;
endtask

task automatic drive_model();
  rm_pc_i       = m_pc;
  rm_gpr_we_i   = m_gwe;
  rm_gpr_addr_i = m_ga;
  rm_gpr_data_i = m_gd;
  rm_csr_we_i   = m_cwe;
  rm_csr_addr_i = m_ca;
  rm_csr_data_i = m_cd;
endtask

// One core retirement against one model step, then all results checked
task automatic run_step(input logic exp_pc, input logic exp_gpr, input logic exp_csr,
                        input logic exp_unk, input logic gpr_cnt, input logic csr_cnt);
  int delay;
  delay = int'($urandom_range(5, 1));
  @(negedge clk_i);
  check_flag("compare_done_o", 1'b0, compare_done_o);
  drive_core();
  rtl_retire_i = 1'b1;
  @(negedge clk_i);
  rtl_retire_i = 1'b0;
  // Hold and model request start together
  check_flag("rtl_hold_o", 1'b1, rtl_hold_o);
  check_flag("rm_step_o", 1'b1, rm_step_o);
  while (!rm_step_o) @(negedge clk_i);
  // Model latency, the core stays held throughout
  repeat (delay) begin
    @(negedge clk_i);
    check_flag("rtl_hold_o", 1'b1, rtl_hold_o);
    check_flag("rm_step_o", 1'b0, rm_step_o);
  end
  drive_model();
  rm_valid_i = 1'b1;
  @(negedge clk_i);
  rm_valid_i = 1'b0;
  while (!compare_done_o) begin
    check_flag("rtl_hold_o", 1'b1, rtl_hold_o);
    @(negedge clk_i);
  end
  exp_pc_cnt  = exp_pc_cnt + CNT_W'(1);
  exp_gpr_cnt = exp_gpr_cnt + CNT_W'(gpr_cnt);
  exp_csr_cnt = exp_csr_cnt + CNT_W'(csr_cnt);
  exp_insn    = exp_insn + CNT_W'(1);
  check_flag("rtl_hold_o", 1'b0, rtl_hold_o);
  check_flag("pc_mismatch_o", exp_pc, pc_mismatch_o);
  check_flag("gpr_mismatch_o", exp_gpr, gpr_mismatch_o);
  check_flag("csr_mismatch_o", exp_csr, csr_mismatch_o);
  check_flag("unknown_csr_o", exp_unk, unknown_csr_o);
  check_flag("limit_o", exp_insn >= MAX_INSNS, limit_o);
  check_count("num_pc_checks_o", exp_pc_cnt, num_pc_checks_o);
  check_count("num_gpr_checks_o", exp_gpr_cnt, num_gpr_checks_o);
  check_count("num_csr_checks_o", exp_csr_cnt, num_csr_checks_o);
  check_count("insn_count_o", exp_insn, insn_count_o);
endtask

task automatic test_matching();
  start_test("matching records");
  make_record(1'b1, reg_addr_t'($urandom_range(31, 1)), 1'b0, '0);
  run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
  make_record(1'b0, 5'd7, 1'b0, '0);
  run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  // x0 is never compared, whatever the data
  make_record(1'b1, '0, 1'b0, '0);
  m_gd = ~c_gd;
  run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  finish_test();
endtask

task automatic test_mismatch();
  start_test("pc and gpr mismatch");
  make_record(1'b1, 5'd12, 1'b0, '0);
  m_pc = c_pc ^ 32'h4;
  run_step(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
  make_record(1'b1, 5'd12, 1'b0, '0);
  m_gd = ~c_gd;
  run_step(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
  finish_test();
endtask

task automatic test_csr_policy();
  start_test("csr policy");
  make_record(1'b0, '0, 1'b1, CSR_MSCRATCH);
  run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
  m_cd = ~c_cd;
  run_step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
  // Model writes a CSR that the core did not
  make_record(1'b0, '0, 1'b1, CSR_MSCRATCH);
  c_cwe = 1'b0;
  run_step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
  make_record(1'b0, '0, 1'b1, CSR_MIP);
  m_cd = ~c_cd;
  run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  make_record(1'b0, '0, 1'b1, CSR_HPMCOUNTER3 + csr_addr_t'(4));
  m_cd = ~c_cd;
  run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  make_record(1'b0, '0, 1'b1, 12'h7C5);
  m_cd = ~c_cd;
  run_step(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
  make_record(1'b0, '0, 1'b1, CSR_MEPC);
  m_cd = ~c_cd;
  run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  deferint_i = 1'b1;
  run_step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
  deferint_i = 1'b0;
  finish_test();
endtask

task automatic test_modes();
  start_test("mode levels");
  make_record(1'b0, '0, 1'b1, CSR_DCSR);
  m_cd = ~c_cd;
  run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  debug_mode_i = 1'b1;
  run_step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
  make_record(1'b0, '0, 1'b1, CSR_DPC);
  m_cd = ~c_cd;
  run_step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
  ignore_dpc_i = 1'b1;
  run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  debug_mode_i = 1'b0;
  ignore_dpc_i = 1'b0;
  // Stall mode drops every CSR check, even one that would fail
  stall_sim_i = 1'b1;
  deferint_i  = 1'b1;
  make_record(1'b0, '0, 1'b1, CSR_MSCRATCH);
  m_cd = ~c_cd;
  run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  make_record(1'b0, '0, 1'b1, CSR_MEPC);
  m_cd = ~c_cd;
  run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  stall_sim_i = 1'b0;
  deferint_i  = 1'b0;
  finish_test();
endtask

task automatic test_hold();
  start_test("hold level");
  apply_reset();
  check_flag("rtl_hold_o", 1'b0, rtl_hold_o);
  check_flag("rm_step_o", 1'b0, rm_step_o);
  check_flag("compare_done_o", 1'b0, compare_done_o);
  check_flag("pc_mismatch_o", 1'b0, pc_mismatch_o);
  check_flag("gpr_mismatch_o", 1'b0, gpr_mismatch_o);
  check_flag("csr_mismatch_o", 1'b0, csr_mismatch_o);
  check_flag("unknown_csr_o", 1'b0, unknown_csr_o);
  check_flag("limit_o", 1'b0, limit_o);
  check_count("insn_count_o", '0, insn_count_o);
  check_count("num_pc_checks_o", '0, num_pc_checks_o);
  check_count("num_gpr_checks_o", '0, num_gpr_checks_o);
  check_count("num_csr_checks_o", '0, num_csr_checks_o);
  make_record(1'b1, 5'd1, 1'b1, CSR_MTVEC);
  run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
  // No retirement pending, so the core is free
  repeat (3) begin
    @(negedge clk_i);
    check_flag("rtl_hold_o", 1'b0, rtl_hold_o);
    check_flag("rm_step_o", 1'b0, rm_step_o);
    check_flag("compare_done_o", 1'b0, compare_done_o);
  end
  finish_test();
endtask

task automatic test_limit();
  start_test("instruction limit");
  while (exp_insn < CNT_W'(MAX_INSNS + 2)) begin
    make_record(1'b1, reg_addr_t'($urandom_range(31, 1)), 1'b0, '0);
    run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
  end
  repeat (4) @(negedge clk_i);
  check_flag("limit_o", 1'b1, limit_o);
  finish_test();
endtask

`endif

/* tb/tb_sc_top.sv */
// Testbench for the step-and-compare checker
// Plays both the core and the reference model around sc_top and runs
// directed tests on the compare results, counters, hold level and limit
`timescale 1ns/1ps

module tb_sc_top import sc_pkg::*; ();

  localparam int          CNT_W        = 32;
  localparam int unsigned MAX_INSNS    = 6;
  localparam int          CLK_HALF     = 5;
  localparam int          RESET_CYCLES = 10;
  localparam int unsigned SEED         = 32'ha0a6_d2dc;
  // About 30 steps of at most 12 cycles each, plus two resets, with wide margin
  localparam int          TIMEOUT_CYCLES = 2000;

  logic             clk_i;
  logic             reset_i;
  logic             rtl_retire_i;
  xlen_t            rtl_pc_i;
  logic             rtl_gpr_we_i;
  reg_addr_t        rtl_gpr_addr_i;
  xlen_t            rtl_gpr_data_i;
  logic             rtl_csr_we_i;
  csr_addr_t        rtl_csr_addr_i;
  xlen_t            rtl_csr_data_i;
  logic             rtl_hold_o;
  logic             rm_step_o;
  logic             rm_valid_i;
  xlen_t            rm_pc_i;
  logic             rm_gpr_we_i;
  reg_addr_t        rm_gpr_addr_i;
  xlen_t            rm_gpr_data_i;
  logic             rm_csr_we_i;
  csr_addr_t        rm_csr_addr_i;
  xlen_t            rm_csr_data_i;
  logic             stall_sim_i;
  logic             deferint_i;
  logic             debug_mode_i;
  logic             ignore_dpc_i;
  logic             compare_done_o;
  logic             pc_mismatch_o;
  logic             gpr_mismatch_o;
  logic             csr_mismatch_o;
  logic             unknown_csr_o;
  logic [CNT_W-1:0] num_pc_checks_o;
  logic [CNT_W-1:0] num_gpr_checks_o;
  logic [CNT_W-1:0] num_csr_checks_o;
  logic [CNT_W-1:0] insn_count_o;
  logic             limit_o;

  // Pending core and model records, set by the tests before each step
  xlen_t            c_pc, m_pc;
  logic             c_gwe, m_gwe;
  reg_addr_t        c_ga, m_ga;
  xlen_t            c_gd, m_gd;
  logic             c_cwe, m_cwe;
  csr_addr_t        c_ca, m_ca;
  xlen_t            c_cd, m_cd;

  // Expected counter values
  logic [CNT_W-1:0] exp_pc_cnt;
  logic [CNT_W-1:0] exp_gpr_cnt;
  logic [CNT_W-1:0] exp_csr_cnt;
  logic [CNT_W-1:0] exp_insn;

  int               num_checks;
  int               num_errors;
  int               test_num;
  int               tests_failed;
  int               err_mark;
  string            cur_test;
  int               cycle_cnt;

  sc_top #(
    .CNT_W     (CNT_W),
    .MAX_INSNS (MAX_INSNS)
  ) dut_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .rtl_retire_i     (rtl_retire_i),
    .rtl_pc_i         (rtl_pc_i),
    .rtl_gpr_we_i     (rtl_gpr_we_i),
    .rtl_gpr_addr_i   (rtl_gpr_addr_i),
    .rtl_gpr_data_i   (rtl_gpr_data_i),
    .rtl_csr_we_i     (rtl_csr_we_i),
    .rtl_csr_addr_i   (rtl_csr_addr_i),
    .rtl_csr_data_i   (rtl_csr_data_i),
    .rtl_hold_o       (rtl_hold_o),
    .rm_step_o        (rm_step_o),
    .rm_valid_i       (rm_valid_i),
    .rm_pc_i          (rm_pc_i),
    .rm_gpr_we_i      (rm_gpr_we_i),
    .rm_gpr_addr_i    (rm_gpr_addr_i),
    .rm_gpr_data_i    (rm_gpr_data_i),
    .rm_csr_we_i      (rm_csr_we_i),
    .rm_csr_addr_i    (rm_csr_addr_i),
    .rm_csr_data_i    (rm_csr_data_i),
    .stall_sim_i      (stall_sim_i),
    .deferint_i       (deferint_i),
    .debug_mode_i     (debug_mode_i),
    .ignore_dpc_i     (ignore_dpc_i),
    .compare_done_o   (compare_done_o),
    .pc_mismatch_o    (pc_mismatch_o),
    .gpr_mismatch_o   (gpr_mismatch_o),
    .csr_mismatch_o   (csr_mismatch_o),
    .unknown_csr_o    (unknown_csr_o),
    .num_pc_checks_o  (num_pc_checks_o),
    .num_gpr_checks_o (num_gpr_checks_o),
    .num_csr_checks_o (num_csr_checks_o),
    .insn_count_o     (insn_count_o),
    .limit_o          (limit_o)
  );

  `include "sc_tb_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the DUT stopped answering in test %0d (%s)",
             cycle_cnt, test_num, cur_test);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    reset_i        = 1'b1;
    rtl_retire_i   = 1'b0;
    rtl_pc_i       = '0;
    rtl_gpr_we_i   = 1'b0;
    rtl_gpr_addr_i = '0;
    rtl_gpr_data_i = '0;
    rtl_csr_we_i   = 1'b0;
    rtl_csr_addr_i = '0;
    rtl_csr_data_i = '0;
    rm_valid_i     = 1'b0;
    rm_pc_i        = '0;
    rm_gpr_we_i    = 1'b0;
    rm_gpr_addr_i  = '0;
    rm_gpr_data_i  = '0;
    rm_csr_we_i    = 1'b0;
    rm_csr_addr_i  = '0;
    rm_csr_data_i  = '0;
    stall_sim_i    = 1'b0;
    deferint_i     = 1'b0;
    debug_mode_i   = 1'b0;
    ignore_dpc_i   = 1'b0;
    num_checks     = 0;
    num_errors     = 0;
    test_num       = 0;
    tests_failed   = 0;
    cur_test       = "reset";

    apply_reset();
    test_matching();
    test_mismatch();
    test_csr_policy();
    test_modes();
    test_hold();
    test_limit();

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             test_num, tests_failed, num_checks, num_errors);
    if (num_errors == 0 && tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+tb
src/sc_pkg.sv
src/sc_retire_capture.sv
src/sc_step_sched.sv
src/sc_csr_filter.sv
src/sc_compare.sv
src/sc_check_counters.sv
src/sc_top.sv
tb/tb_sc_top.sv

/* Makefile */
# Verilator build and run for the step-and-compare checker

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_sc_top
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Simulation PASSED

SOURCES := $(filter %.sv,$(shell cat $(FILELIST)))
HEADERS := $(wildcard tb/*.svh)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, so a crash without the pass line also fails
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
